// File: Bender.yml
package:
  name: axi_apb_bridge

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/apb_bridge_pkg.sv
      - hw/apb_addr_decoder.sv
      - hw/axi_lite_slave_port.sv
      - hw/apb_master_fsm.sv
      - hw/axi_lite_resp_port.sv
      - hw/axi_apb_bridge_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - test/axi_apb_bridge_assertions.sv
      - test/axi_apb_bridge_tb.sv

// File: hw/apb_addr_decoder.sv
`timescale 1ns/10ps
`default_nettype none

`include "apb_bridge_consts.svh"

module apb_addr_decoder (
    input  logic [`ADDR_W-1:0]      addr,
    output logic [`APB_SLAVE_N-1:0] sel,
    output logic                    miss
);

    function automatic logic in_win(
        input logic [`ADDR_W-1:0] a,
        input logic [`ADDR_W-1:0] base
    );
        return (a >= base) && (a < base + `APB_WIN_SIZE);
    endfunction

    // Windows do not overlap, so at most one bit is set
    always_comb begin
        sel    = '0;
        sel[0] = in_win(addr, `APB_BASE_0);
        sel[1] = in_win(addr, `APB_BASE_1);
        sel[2] = in_win(addr, `APB_BASE_2);
        sel[3] = in_win(addr, `APB_BASE_3);
    end

    assign miss = ~|sel;   // Hole in the map

endmodule

`default_nettype wire

// File: hw/apb_bridge_consts.svh
`ifndef APB_BRIDGE_CONSTS_SVH
`define APB_BRIDGE_CONSTS_SVH

// Peripheral map
`define APB_SLAVE_N   4
`define APB_WIN_SIZE  32'd4096

// Window bases, anything from 0x4000 up decodes to nothing
`define APB_BASE_0    32'h0000_0000
`define APB_BASE_1    32'h0000_1000
`define APB_BASE_2    32'h0000_2000
`define APB_BASE_3    32'h0000_3000

// Bus widths
`define ADDR_W        32
`define DATA_W        32
`define STRB_W        4

`endif

// File: hw/apb_bridge_pkg.sv
`default_nettype none

`include "apb_bridge_consts.svh"

package apb_bridge_pkg;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } bridge_op_e;

    // AXI encoding, EXOKAY never produced
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } axi_resp_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SETUP,
        ST_ACCESS,
        ST_RESP
    } apb_state_e;

    typedef struct packed {
        bridge_op_e         op;
        logic [`ADDR_W-1:0] addr;
        logic [2:0]         prot;
        logic [`DATA_W-1:0] wdata;
        logic [`STRB_W-1:0] strb;
    } bridge_req_t;

    // Shared by every slave, only psel differs
    typedef struct packed {
        logic [`ADDR_W-1:0] paddr;
        logic               pwrite;
        logic [2:0]         pprot;
        logic [`STRB_W-1:0] pstrb;
        logic [`DATA_W-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic               pready;
        logic               pslverr;
        logic [`DATA_W-1:0] prdata;
    } apb_rsp_t;

    typedef struct packed {
        bridge_op_e         op;
        logic [`DATA_W-1:0] rdata;
        axi_resp_e          resp;
    } bridge_rsp_t;

endpackage

`default_nettype wire

// File: hw/apb_master_fsm.sv
`timescale 1ns/10ps
`default_nettype none

`include "apb_bridge_consts.svh"

module apb_master_fsm (
    input  logic                                       clk,
    input  logic                                       rst,

    input  apb_bridge_pkg::bridge_req_t                req,
    input  logic                                       req_valid,

    output apb_bridge_pkg::apb_req_t                   apb_out,
    output logic [`APB_SLAVE_N-1:0]                    psel,
    output logic                                       penable,
    input  apb_bridge_pkg::apb_rsp_t [`APB_SLAVE_N-1:0] apb_in,

    output apb_bridge_pkg::bridge_rsp_t                rsp,
    output logic                                       rsp_valid
);

    apb_bridge_pkg::apb_state_e          state;
    apb_bridge_pkg::bridge_req_t         req_q;
    apb_bridge_pkg::apb_rsp_t            slv_rsp;
    logic [`APB_SLAVE_N-1:0]             dec_sel;
    logic                                dec_miss;
    logic [$clog2(`APB_SLAVE_N)-1:0]     dec_idx;
    logic [`APB_SLAVE_N-1:0]             sel_q;
    logic [$clog2(`APB_SLAVE_N)-1:0]     idx_q;
    logic                                miss_q;
    logic                                xfer_end;

    apb_addr_decoder apb_addr_decoder_i (
        .addr (req.addr),
        .sel  (dec_sel),
        .miss (dec_miss)
    );

    // One-hot to index for the return mux
    always_comb begin
        dec_idx = '0;
        for (int k = 0; k < `APB_SLAVE_N; k++) begin
            if (dec_sel[k])
                dec_idx = $bits(dec_idx)'(k);
        end
    end

    assign slv_rsp  = apb_in[idx_q];
    assign xfer_end = (state == apb_bridge_pkg::ST_ACCESS) && slv_rsp.pready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= apb_bridge_pkg::ST_IDLE;
        end else begin
            case (state)
                apb_bridge_pkg::ST_IDLE:
                    if (req_valid)
                        state <= apb_bridge_pkg::ST_SETUP;
                // A miss skips the access phase
                apb_bridge_pkg::ST_SETUP:
                    state <= miss_q ? apb_bridge_pkg::ST_RESP : apb_bridge_pkg::ST_ACCESS;
                apb_bridge_pkg::ST_ACCESS:
                    if (slv_rsp.pready)
                        state <= apb_bridge_pkg::ST_RESP;
                default:
                    state <= apb_bridge_pkg::ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == apb_bridge_pkg::ST_IDLE && req_valid) begin
            req_q  <= req;
            sel_q  <= dec_sel;
            idx_q  <= dec_idx;
            miss_q <= dec_miss;
        end
        if (state == apb_bridge_pkg::ST_SETUP && miss_q) begin
            rsp.op    <= req_q.op;
            rsp.rdata <= '0;
            rsp.resp  <= apb_bridge_pkg::RESP_DECERR;
        end else if (xfer_end) begin
            rsp.op    <= req_q.op;
            rsp.rdata <= slv_rsp.prdata;
            rsp.resp  <= slv_rsp.pslverr ? apb_bridge_pkg::RESP_SLVERR
                                         : apb_bridge_pkg::RESP_OKAY;
        end
    end

    assign apb_out.paddr  = req_q.addr;
    assign apb_out.pwrite = (req_q.op == apb_bridge_pkg::OP_WRITE);
    assign apb_out.pprot  = req_q.prot;
    assign apb_out.pstrb  = apb_out.pwrite ? req_q.strb : '0;   // Zero on reads
    assign apb_out.pwdata = req_q.wdata;

    assign psel = (state == apb_bridge_pkg::ST_SETUP || state == apb_bridge_pkg::ST_ACCESS)
                ? sel_q : '0;
    assign penable   = (state == apb_bridge_pkg::ST_ACCESS);
    assign rsp_valid = (state == apb_bridge_pkg::ST_RESP);

endmodule

`default_nettype wire

// File: hw/axi_apb_bridge_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "apb_bridge_consts.svh"

module axi_apb_bridge_top (
    input  logic                                       clk,
    input  logic                                       rst,

    input  logic [`ADDR_W-1:0]                         araddr,
    input  logic [2:0]                                 arprot,
    input  logic                                       arvalid,
    output logic                                       arready,

    input  logic [`ADDR_W-1:0]                         awaddr,
    input  logic [2:0]                                 awprot,
    input  logic                                       awvalid,
    output logic                                       awready,

    input  logic [`DATA_W-1:0]                         wdata,
    input  logic [`STRB_W-1:0]                         wstrb,
    input  logic                                       wvalid,
    output logic                                       wready,

    output logic [1:0]                                 bresp,
    output logic                                       bvalid,
    input  logic                                       bready,

    output logic [`DATA_W-1:0]                         rdata,
    output logic [1:0]                                 rresp,
    output logic                                       rvalid,
    input  logic                                       rready,

    output apb_bridge_pkg::apb_req_t                   apb_out,
    output logic [`APB_SLAVE_N-1:0]                    psel,
    output logic                                       penable,
    input  apb_bridge_pkg::apb_rsp_t [`APB_SLAVE_N-1:0] apb_in
);

    apb_bridge_pkg::bridge_req_t req;
    apb_bridge_pkg::bridge_rsp_t rsp;
    logic                        req_valid;
    logic                        rsp_valid;
    logic                        done;

    axi_lite_slave_port axi_lite_slave_port_i (
        .clk       (clk),
        .rst       (rst),
        .araddr    (araddr),
        .arprot    (arprot),
        .arvalid   (arvalid),
        .arready   (arready),
        .awaddr    (awaddr),
        .awprot    (awprot),
        .awvalid   (awvalid),
        .awready   (awready),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .wvalid    (wvalid),
        .wready    (wready),
        .done      (done),
        .req       (req),
        .req_valid (req_valid)
    );

    apb_master_fsm apb_master_fsm_i (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .req_valid (req_valid),
        .apb_out   (apb_out),
        .psel      (psel),
        .penable   (penable),
        .apb_in    (apb_in),
        .rsp       (rsp),
        .rsp_valid (rsp_valid)
    );

    axi_lite_resp_port axi_lite_resp_port_i (
        .clk       (clk),
        .rst       (rst),
        .rsp       (rsp),
        .rsp_valid (rsp_valid),
        .bresp     (bresp),
        .bvalid    (bvalid),
        .bready    (bready),
        .rdata     (rdata),
        .rresp     (rresp),
        .rvalid    (rvalid),
        .rready    (rready),
        .done      (done)
    );

endmodule

`default_nettype wire

// File: hw/axi_lite_resp_port.sv
`timescale 1ns/10ps
`default_nettype none

`include "apb_bridge_consts.svh"

module axi_lite_resp_port (
    input  logic                         clk,
    input  logic                         rst,

    input  apb_bridge_pkg::bridge_rsp_t  rsp,
    input  logic                         rsp_valid,

    output logic [1:0]                   bresp,
    output logic                         bvalid,
    input  logic                         bready,

    output logic [`DATA_W-1:0]           rdata,
    output logic [1:0]                   rresp,
    output logic                         rvalid,
    input  logic                         rready,

    output logic                         done
);

    logic is_wr;

    assign is_wr = (rsp.op == apb_bridge_pkg::OP_WRITE);

    always_ff @(posedge clk) begin
        if (rst) begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            if (rsp_valid && is_wr)
                bvalid <= 1'b1;
            else if (bready)
                bvalid <= 1'b0;
            if (rsp_valid && !is_wr)
                rvalid <= 1'b1;
            else if (rready)
                rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_valid && is_wr)
            bresp <= rsp.resp;
        if (rsp_valid && !is_wr) begin
            rdata <= rsp.rdata;
            rresp <= rsp.resp;
        end
    end

    // Frees the input side
    assign done = (bvalid & bready) | (rvalid & rready);

endmodule

`default_nettype wire

// File: hw/axi_lite_slave_port.sv
`timescale 1ns/10ps
`default_nettype none

`include "apb_bridge_consts.svh"

module axi_lite_slave_port (
    input  logic                         clk,
    input  logic                         rst,

    input  logic [`ADDR_W-1:0]           araddr,
    input  logic [2:0]                   arprot,
    input  logic                         arvalid,
    output logic                         arready,

    input  logic [`ADDR_W-1:0]           awaddr,
    input  logic [2:0]                   awprot,
    input  logic                         awvalid,
    output logic                         awready,

    input  logic [`DATA_W-1:0]           wdata,
    input  logic [`STRB_W-1:0]           wstrb,
    input  logic                         wvalid,
    output logic                         wready,

    input  logic                         done,
    output apb_bridge_pkg::bridge_req_t  req,
    output logic                         req_valid
);

    logic                 busy;      // One transaction in flight
    logic                 aw_held;
    logic                 w_held;
    logic [`ADDR_W-1:0]   aw_addr_q;
    logic [2:0]           aw_prot_q;
    logic [`DATA_W-1:0]   w_data_q;
    logic [`STRB_W-1:0]   w_strb_q;
    logic                 ar_hs;
    logic                 aw_hs;
    logic                 w_hs;
    logic                 wr_go;

    assign arready = ~busy;
    assign awready = ~busy & ~aw_held;
    assign wready  = ~busy & ~w_held;

    assign ar_hs = arvalid & arready;
    assign aw_hs = awvalid & awready;
    assign w_hs  = wvalid & wready;

    // Write goes once both halves are in, reads win a tie
    assign wr_go = ~busy & ~ar_hs & (aw_held | aw_hs) & (w_held | w_hs);

    always_ff @(posedge clk) begin
        if (rst) begin
            busy      <= 1'b0;
            aw_held   <= 1'b0;
            w_held    <= 1'b0;
            req_valid <= 1'b0;
        end else begin
            req_valid <= ar_hs | wr_go;
            if (ar_hs | wr_go)
                busy <= 1'b1;
            else if (done)
                busy <= 1'b0;
            if (wr_go)
                aw_held <= 1'b0;
            else if (aw_hs)
                aw_held <= 1'b1;
            if (wr_go)
                w_held <= 1'b0;
            else if (w_hs)
                w_held <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (aw_hs) begin
            aw_addr_q <= awaddr;
            aw_prot_q <= awprot;
        end
        if (w_hs) begin
            w_data_q <= wdata;
            w_strb_q <= wstrb;
        end
        if (ar_hs) begin
            req.op    <= apb_bridge_pkg::OP_READ;
            req.addr  <= araddr;
            req.prot  <= arprot;
            req.wdata <= '0;
            req.strb  <= '0;
        end else if (wr_go) begin
            req.op    <= apb_bridge_pkg::OP_WRITE;
            req.addr  <= aw_held ? aw_addr_q : awaddr;   // Bypass when AW lands this edge
            req.prot  <= aw_held ? aw_prot_q : awprot;
            req.wdata <= w_held ? w_data_q : wdata;
            req.strb  <= w_held ? w_strb_q : wstrb;
        end
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+hw
hw/apb_bridge_pkg.sv
hw/apb_addr_decoder.sv
hw/axi_lite_slave_port.sv
hw/apb_master_fsm.sv
hw/axi_lite_resp_port.sv
hw/axi_apb_bridge_top.sv
test/axi_apb_bridge_assertions.sv
test/axi_apb_bridge_tb.sv

// File: test/axi_apb_bridge_assertions.sv
`timescale 1ns/10ps
`default_nettype none

`include "apb_bridge_consts.svh"

module axi_apb_bridge_assertions (
    input logic                    clk,
    input logic                    rst,
    input logic [`APB_SLAVE_N-1:0] psel,
    input logic                    penable,
    input logic                    bvalid,
    input logic                    bready,
    input logic                    rvalid,
    input logic                    rready
);

    // APB access phase only with a selected slave
    assert property (@(posedge clk) disable iff (rst) penable |-> |psel)
        else $error("penable high with no psel bit set");

    assert property (@(posedge clk) disable iff (rst) $onehot0(psel))
        else $error("more than one psel bit high");

    // Response valid stays up until the master takes it
    assert property (@(posedge clk) disable iff (rst) bvalid && !bready |=> bvalid)
        else $error("bvalid dropped before its handshake");

    assert property (@(posedge clk) disable iff (rst) rvalid && !rready |=> rvalid)
        else $error("rvalid dropped before its handshake");

endmodule

bind axi_apb_bridge_top axi_apb_bridge_assertions axi_apb_bridge_assertions_i (
    .clk     (clk),
    .rst     (rst),
    .psel    (psel),
    .penable (penable),
    .bvalid  (bvalid),
    .bready  (bready),
    .rvalid  (rvalid),
    .rready  (rready)
);

`default_nettype wire

// File: test/axi_apb_bridge_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "apb_bridge_consts.svh"

module axi_apb_bridge_tb;

    typedef enum logic [1:0] {VEC_READ, VEC_WRITE, VEC_BOTH} vec_op_e;

    typedef struct packed {
        vec_op_e     op;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  strb;
        logic [2:0]  prot;
        logic [31:0] exp_rdata;
        logic [1:0]  exp_resp;
    } vector_t;

    logic clk;
    logic rst;
    logic [`ADDR_W-1:0] araddr, awaddr;
    logic [2:0] arprot, awprot;
    logic arvalid, arready, awvalid, awready, wvalid, wready;
    logic [`DATA_W-1:0] wdata, rdata;
    logic [`STRB_W-1:0] wstrb;
    logic [1:0] bresp, rresp;
    logic bvalid, bready, rvalid, rready;
    apb_bridge_pkg::apb_req_t apb_out;
    logic [`APB_SLAVE_N-1:0] psel;
    logic penable;
    apb_bridge_pkg::apb_rsp_t [`APB_SLAVE_N-1:0] apb_in;

    vector_t     vectors[$];
    logic [31:0] mem [`APB_SLAVE_N][16];
    int          wait_cnt [`APB_SLAVE_N];
    logic [31:0] lcg_state = 32'hd98a;
    int          checks = 0;
    int          errors = 0;
    bit          loaded = 0;
    bit          psel_seen;
    logic [2:0]  prot_seen;

    axi_apb_bridge_top axi_apb_bridge_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // APB slave models, slave k stalls k access cycles
    always_comb begin
        logic rdy;
        logic err;
        for (int k = 0; k < `APB_SLAVE_N; k++) begin
            rdy = psel[k] && penable && (wait_cnt[k] == k);
            err = rdy && (k == 3) && (apb_out.paddr[11:0] >= 12'h800);
            apb_in[k].pready  = rdy;
            apb_in[k].pslverr = err;
            apb_in[k].prdata  = (rdy && !apb_out.pwrite && !err) ? mem[k][apb_out.paddr[5:2]] : '0;
        end
    end

    always @(posedge clk) begin
        for (int k = 0; k < `APB_SLAVE_N; k++) begin
            if (psel[k] && penable && !apb_in[k].pready)
                wait_cnt[k] <= wait_cnt[k] + 1;
            else
                wait_cnt[k] <= 0;
            if (apb_in[k].pready && apb_out.pwrite && !apb_in[k].pslverr) begin
                for (int b = 0; b < 4; b++)
                    if (apb_out.pstrb[b])
                        mem[k][apb_out.paddr[5:2]][8*b +: 8] <= apb_out.pwdata[8*b +: 8];
            end
        end
    end

    always @(negedge clk) begin
        if (|psel)
            psel_seen = 1'b1;
        if (|psel && penable)
            prot_seen = apb_out.pprot;
    end

    function automatic logic [1:0] next_delay();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[17:16];   // Low bits cycle too fast
    endfunction

    task automatic compare_value(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        assert (got === exp)
        else begin
            errors++;
            $display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_condition(input bit cond, input string msg);
        checks++;
        assert (cond)
        else begin
            errors++;
            $display("Error at %0t: %s", $time, msg);
        end
    endtask

    task automatic load_vectors();
        int fd;
        int n;
        string line;
        logic [31:0] f_op, f_addr, f_wdata, f_strb, f_prot, f_rdata, f_resp;
        fd = $fopen("test/bridge_input.txt", "r");
        check_condition(fd != 0, "could not open the stimulus file test/bridge_input.txt");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) == 0)
                    n = 0;
                else
                    n = $sscanf(line, "%h %h %h %h %h %h %h", f_op, f_addr, f_wdata, f_strb,
                                f_prot, f_rdata, f_resp);
                if (n == 7)   // Comment and blank lines give fewer fields
                    vectors.push_back({vec_op_e'(f_op[1:0]), f_addr, f_wdata, f_strb[3:0],
                                       f_prot[2:0], f_rdata, f_resp[1:0]});
            end
            $fclose(fd);
            check_condition(vectors.size() > 0, "the stimulus file holds no vectors");
        end
    endtask

    task automatic present(input vector_t v, input bit do_rd, input bit do_wr);
        logic ar_go, aw_go, w_go;
        @(posedge clk);
        #1;
        if (do_rd) begin
            araddr  = v.addr;
            arprot  = v.prot;
            arvalid = 1'b1;
        end
        if (do_wr) begin
            awaddr  = v.addr;
            awprot  = v.prot;
            awvalid = 1'b1;
            wdata   = v.wdata;
            wstrb   = v.strb;
            wvalid  = 1'b1;
        end
        while (arvalid || awvalid || wvalid) begin
            @(negedge clk);
            ar_go = arvalid & arready;
            aw_go = awvalid & awready;
            w_go  = wvalid & wready;
            @(posedge clk);
            #1;
            if (ar_go) arvalid = 1'b0;
            if (aw_go) awvalid = 1'b0;
            if (w_go)  wvalid  = 1'b0;
        end
    endtask

    task automatic check_held(input bit want_read, input logic [31:0] data,
                              input logic [1:0] resp);
        compare_value("response valid", want_read ? rvalid : bvalid, 1);
        compare_value("held response", want_read ? rresp : bresp, resp);
        if (want_read)
            compare_value("held rdata", rdata, data);
        check_condition(!arready && !awready && !wready,
                        "a new request could be accepted while a response was pending");
    endtask

    // A write held behind a read lets AR open for one cycle before it issues
    task automatic collect_resp(input bit want_read, input bit write_held,
                                output logic [31:0] data, output logic [1:0] resp);
        int hold;
        do begin
            @(negedge clk);
            if (want_read)
                check_condition(!bvalid, "write response arrived before the read response");
            if (write_held)
                check_condition(!awready && !wready,
                                "AW or W was ready again before the held write finished");
            else
                check_condition(!arready && !awready && !wready,
                                "a new request could be accepted before the response");
        end while (!(want_read ? rvalid : bvalid));
        data = want_read ? rdata : '0;
        resp = want_read ? rresp : bresp;
        hold = next_delay();
        repeat (hold) begin
            @(negedge clk);
            check_held(want_read, data, resp);
        end
        @(posedge clk);
        #1;
        if (want_read) rready = 1'b1;
        else bready = 1'b1;
        @(negedge clk);
        check_held(want_read, data, resp);
        @(posedge clk);
        #1;
        rready = 1'b0;
        bready = 1'b0;
    endtask

    task automatic run_vector(input vector_t v);
        logic [31:0] got_data;
        logic [1:0]  got_resp;
        psel_seen = 1'b0;
        prot_seen = 'x;
        present(v, v.op != VEC_WRITE, v.op != VEC_READ);
        if (v.op != VEC_WRITE) begin
            collect_resp(1'b1, 1'b0, got_data, got_resp);
            compare_value($sformatf("rdata at %h", v.addr), got_data, v.exp_rdata);
            compare_value($sformatf("rresp at %h", v.addr), got_resp, v.exp_resp);
        end
        if (v.op != VEC_READ) begin
            collect_resp(1'b0, v.op == VEC_BOTH, got_data, got_resp);
            compare_value($sformatf("bresp at %h", v.addr), got_resp, v.exp_resp);
        end
        if (v.exp_resp == apb_bridge_pkg::RESP_DECERR)
            check_condition(!psel_seen, "psel rose for an unmapped address");
        else
            compare_value("pprot", prot_seen, v.prot);
    endtask

    initial begin
        int limit;
        wait (loaded);
        limit = vectors.size() * 40 + 10;   // Reset and drain
        repeat (limit) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d cycles", limit);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        rst = 1'b1;
        araddr = '0;
        arprot = '0;
        arvalid = 1'b0;
        awaddr = '0;
        awprot = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        rready = 1'b0;
        for (int k = 0; k < `APB_SLAVE_N; k++) begin
            wait_cnt[k] = 0;
            for (int w = 0; w < 16; w++)
                mem[k][w] = {16'hc0de, 16'(k * 4096 + w * 4)};   // Word address in low half
        end
        load_vectors();
        loaded = 1'b1;
        repeat (5) @(posedge clk);
        #1 rst = 1'b0;
        foreach (vectors[i])
            run_vector(vectors[i]);
        repeat (4) @(posedge clk);
        $display("Vectors: %0d  checks: %0d  errors: %0d", vectors.size(), checks, errors);
        if (errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

// File: test/bridge_input.txt
# op: 0 read, 1 write, 2 read and write together; resp: 0 OKAY, 2 SLVERR, 3 DECERR
# op addr wdata wstrb prot exp_rdata exp_resp
0 00000010 00000000 0 0 c0de0010 0
1 00000004 11223344 f 0 00000000 0
0 00000004 00000000 0 0 11223344 0
1 00001008 55667788 f 2 00000000 0
0 00001008 00000000 0 2 55667788 0
1 0000200c 99aabbcc f 1 00000000 0
0 0000200c 00000000 0 1 99aabbcc 0
1 00003020 deadbeef f 3 00000000 0
0 00003020 00000000 0 3 deadbeef 0
1 00000004 a5a5a5a5 5 0 00000000 0
0 00000004 00000000 0 0 11a533a5 0
1 00002030 0000ff00 2 0 00000000 0
0 00002030 00000000 0 0 c0deff30 0
1 00004000 12345678 f 0 00000000 3
0 00008010 00000000 0 0 00000000 3
1 00003800 cafef00d f 0 00000000 2
0 00003ffc 00000000 0 0 00000000 2
0 00003000 00000000 0 0 c0de3000 0
2 00001008 0badc0de f 0 55667788 0
0 00001008 00000000 0 0 0badc0de 0
